// ==== project.f ====
uart_frame_pkg.sv
uart_tx.sv
uart_rx.sv
byte_fifo.sv
frame_tx.sv
frame_rx.sv
wb_frame_regs.sv
uart_frame_top.sv
tb_uart_frame.sv

// ==== tb_uart_frame.sv ====
/*
 * testbench for the uart frame controller
 * uart loopback, wishbone bus tasks, byte queue model, checker, timeout
 */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_frame;
	import uart_frame_pkg::*;

	// 20 frames of 20 bytes at about 100 cycles per byte, plus margin
	localparam int MAX_CYCLES = 20 * 20 * 100 + 5000;

	logic    sys_clk;
	logic    sys_rst_n;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	byte_t   wb_wdata;
	byte_t   wb_rdata;
	logic    wb_ack;
	wire     uart_line;
	integer  seed;
	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;
	int      err_reads;
	byte_t   model_q[$];
	byte_t   exp_frames;
	byte_t   junk;

	// txd looped straight back into rxd
	uart_frame_top #(.CLKS_PER_BIT(8)) UUT (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.uart_rxd(uart_line), .uart_txd(uart_line)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic compare(input string name, input byte_t actual, input byte_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// one classic cycle, inputs change on the falling edge
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input byte_t wdata,
			output byte_t rdata);
		@(negedge sys_clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = wdata;
		@(negedge sys_clk);
		while (!wb_ack)
			@(negedge sys_clk);
		rdata  = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(input wb_adr_t adr, input byte_t data);
		bus_cycle(1'b1, adr, data, junk);
	endtask

	task automatic read_reg(input wb_adr_t adr, output byte_t data);
		bus_cycle(1'b0, adr, 8'h00, data);
	endtask

	task automatic expect_reg(input wb_adr_t adr, input string name, input byte_t expected);
		byte_t v;
		read_reg(adr, v);
		compare(name, v, expected);
	endtask

	function automatic byte_t rand_byte();
		byte_t b;
		b = FRAME_DELIM;
		while (b == FRAME_DELIM)
			b = byte_t'($random(seed));
		return b;
	endfunction

	task automatic load_bytes(input int n);
		byte_t b;
		for (int i = 0; i < n; i++) begin
			b = rand_byte();
			write_reg(REG_DATA, b);
			model_q.push_back(b);
		end
	endtask

	// status polling clears the sticky error, so count what it sees
	task automatic wait_idle();
		byte_t st;
		st = 8'h01;
		while (st[0]) begin
			read_reg(REG_CTRL, st);
			if (st[3])
				err_reads++;
		end
	endtask

	task automatic check_rx(input int n);
		byte_t v;
		compare("rx_level", UUT.rx_level, byte_t'(n));
		expect_reg(REG_LEVEL, "level", byte_t'(n));
		for (int i = 0; i < n; i++) begin
			read_reg(REG_DATA, v);
			compare("rx_data", v, model_q.pop_front());
		end
	endtask

	// a zero length never starts a frame
	task automatic finish_frame(input int n);
		err_reads = 0;
		wait_idle();
		if (n != 0)
			exp_frames++;
		compare("rx_error_reads", byte_t'(err_reads), 8'h00);
		expect_reg(REG_FRAMES, "frame_count", exp_frames);
		check_rx(n);
	endtask

	task automatic good_frame(input int n);
		load_bytes(n);
		write_reg(REG_CTRL, byte_t'(n));
		finish_frame(n);
	endtask

	initial begin
		int n;
		seed       = 32'h24fc_d66d;
		exp_frames = 8'h00;
		sys_rst_n  = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = REG_DATA;
		wb_wdata   = 8'h00;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;

		compare("uart_txd", uart_line, 8'h01);
		expect_reg(REG_CTRL, "status", 8'h02);
		expect_reg(REG_LEVEL, "level", 8'h00);
		expect_reg(REG_FRAMES, "frame_count", 8'h00);

		repeat (8) begin
			n = $unsigned($random(seed)) % 13;
			good_frame(n);
		end

		// fill the tx fifo, then drain it with one frame
		load_bytes(16);
		expect_reg(REG_CTRL, "status", 8'h06);
		write_reg(REG_CTRL, 8'd16);
		finish_frame(16);

		// second frame runs out of rx space and is dropped
		err_reads = 0;
		load_bytes(12);
		write_reg(REG_CTRL, 8'd12);
		wait_idle();
		load_bytes(12);
		write_reg(REG_CTRL, 8'd12);
		wait_idle();
		exp_frames++;
		compare("rx_error_reads", byte_t'(err_reads), 8'h01);
		expect_reg(REG_CTRL, "status", 8'h00);
		repeat (12) junk = model_q.pop_back();
		expect_reg(REG_FRAMES, "frame_count", exp_frames);
		check_rx(12);

		// "&" then a plain byte inside the payload
		err_reads = 0;
		write_reg(REG_DATA, rand_byte());
		write_reg(REG_DATA, FRAME_DELIM);
		write_reg(REG_DATA, rand_byte());
		write_reg(REG_DATA, rand_byte());
		write_reg(REG_CTRL, 8'd4);
		wait_idle();
		compare("rx_error_reads", byte_t'(err_reads), 8'h01);
		expect_reg(REG_CTRL, "status", 8'h02);
		expect_reg(REG_FRAMES, "frame_count", exp_frames);
		expect_reg(REG_LEVEL, "level", 8'h00);
		good_frame(1 + $unsigned($random(seed)) % 12);

		// spare bytes would go out if the second start were taken
		n = 2 + $unsigned($random(seed)) % 8;
		load_bytes(n);
		repeat (4) write_reg(REG_DATA, rand_byte());
		write_reg(REG_CTRL, byte_t'(n));
		write_reg(REG_CTRL, 8'd4);
		finish_frame(n);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_frame_top.sv ====
/*
 * uart frame controller top level
 * register slave, tx and rx fifos, framer, deframer, uart engines
 */
`timescale 1ns/1ns
`default_nettype none

module uart_frame_top #(
	parameter int CLKS_PER_BIT = 868,
	parameter int FIFO_AW      = 4
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire uart_frame_pkg::wb_adr_t wb_adr,
	input  wire uart_frame_pkg::byte_t   wb_wdata,
	output uart_frame_pkg::byte_t   wb_rdata,
	output logic                   wb_ack,
	input  wire                    uart_rxd,
	output logic                   uart_txd
);
	import uart_frame_pkg::*;

	// transmit path
	logic  tx_push;
	byte_t tx_push_data;
	logic  tx_full;
	logic  tx_empty;
	logic  tx_pop;
	byte_t tx_head;
	logic  frame_start;
	len_t  frame_length;
	logic  tx_busy;
	byte_t byte_out;
	logic  byte_req;
	logic  byte_done;

	// receive path
	byte_t rx_byte;
	logic  rx_valid;
	logic  rx_push;
	byte_t rx_push_data;
	logic  rx_commit;
	logic  rx_drop;
	logic  rx_full;
	logic  rx_pop;
	byte_t rx_head;
	logic  rx_empty;
	len_t  rx_level;
	logic  frame_good;
	logic  frame_error;

	wb_frame_regs u_regs (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_full),
		.frame_start(frame_start), .frame_length(frame_length), .tx_busy(tx_busy),
		.rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty), .rx_level(rx_level),
		.frame_good(frame_good), .frame_error(frame_error)
	);

	// every tx push is final, no rollback
	byte_fifo #(.FIFO_AW(FIFO_AW)) tx_fifo (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.push(tx_push), .push_data(tx_push_data), .pop(tx_pop), .head(tx_head),
		.commit(1'b1), .drop(1'b0), .full(tx_full), .empty(tx_empty), .level()
	);

	frame_tx u_frame_tx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.start(frame_start), .length(frame_length), .busy(tx_busy),
		.fifo_head(tx_head), .fifo_empty(tx_empty), .fifo_pop(tx_pop),
		.byte_out(byte_out), .byte_req(byte_req), .byte_done(byte_done)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.tx_data(byte_out), .tx_req(byte_req), .txd(uart_txd), .tx_done(byte_done)
	);

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rxd(uart_rxd), .rx_data(rx_byte), .rx_valid(rx_valid)
	);

	frame_rx u_frame_rx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rx_data(rx_byte), .rx_valid(rx_valid),
		.fifo_push(rx_push), .fifo_data(rx_push_data), .fifo_commit(rx_commit),
		.fifo_drop(rx_drop), .fifo_full(rx_full),
		.frame_good(frame_good), .frame_error(frame_error)
	);

	byte_fifo #(.FIFO_AW(FIFO_AW)) rx_fifo (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.push(rx_push), .push_data(rx_push_data), .pop(rx_pop), .head(rx_head),
		.commit(rx_commit), .drop(rx_drop), .full(rx_full), .empty(rx_empty),
		.level(rx_level)
	);

endmodule

`default_nettype wire

// ==== wb_frame_regs.sv ====
/*
 * wishbone classic register slave
 * data, control/status, rx level and good frame count registers
 */
`timescale 1ns/1ns
`default_nettype none

module wb_frame_regs (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire uart_frame_pkg::wb_adr_t wb_adr,
	input  wire uart_frame_pkg::byte_t   wb_wdata,
	output uart_frame_pkg::byte_t   wb_rdata,
	output logic                   wb_ack,
	output logic                   tx_push,
	output uart_frame_pkg::byte_t   tx_push_data,
	input  wire                    tx_full,
	output logic                   frame_start,
	output uart_frame_pkg::len_t    frame_length,
	input  wire                    tx_busy,
	output logic                   rx_pop,
	input  wire uart_frame_pkg::byte_t   rx_head,
	input  wire                    rx_empty,
	input  wire uart_frame_pkg::len_t    rx_level,
	input  wire                    frame_good,
	input  wire                    frame_error
);
	import uart_frame_pkg::*;

	logic  req;
	logic  accept;
	logic  wr_acc;
	logic  rd_acc;
	logic  err_sticky;
	len_t  frame_cnt;
	byte_t status;

	assign req    = wb_cyc && wb_stb && !wb_ack;
	// data write into a full tx fifo waits here
	assign accept = req && !(wb_we && (wb_adr == REG_DATA) && tx_full);
	assign wr_acc = accept && wb_we;
	assign rd_acc = accept && !wb_we;

	assign tx_push      = wr_acc && (wb_adr == REG_DATA);
	assign tx_push_data = wb_wdata;
	assign frame_start  = wr_acc && (wb_adr == REG_CTRL) && (wb_wdata != '0) && !tx_busy;
	assign frame_length = wb_wdata;
	assign rx_pop       = rd_acc && (wb_adr == REG_DATA) && !rx_empty;
	assign status       = {4'b0000, err_sticky, tx_full, rx_empty, tx_busy};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wb_ack     <= 1'b0;
			err_sticky <= 1'b0;
			frame_cnt  <= '0;
		end else begin
			wb_ack <= accept;
			// a new error wins over the clearing read
			if (frame_error)
				err_sticky <= 1'b1;
			else if (rd_acc && (wb_adr == REG_CTRL))
				err_sticky <= 1'b0;
			if (frame_good)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rd_acc) begin
			unique case (wb_adr)
				REG_DATA:   wb_rdata <= rx_empty ? '0 : rx_head;
				REG_CTRL:   wb_rdata <= status;
				REG_LEVEL:  wb_rdata <= rx_level;
				REG_FRAMES: wb_rdata <= frame_cnt;
				default:    wb_rdata <= '0;
			endcase
		end
	end

	// a start taken here must launch the framer
	a_start_taken: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		frame_start |=> tx_busy)
		else $error("frame start written but the framer stayed idle");

endmodule

`default_nettype wire

// ==== frame_rx.sv ====
/*
 * receive deframer
 * hunts for "&&", pushes payload tentatively, commits on "&&" or drops
 */
`timescale 1ns/1ns
`default_nettype none

module frame_rx (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire uart_frame_pkg::byte_t rx_data,
	input  wire                   rx_valid,
	output logic                  fifo_push,
	output uart_frame_pkg::byte_t  fifo_data,
	output logic                  fifo_commit,
	output logic                  fifo_drop,
	input  wire                   fifo_full,
	output logic                  frame_good,
	output logic                  frame_error
);
	import uart_frame_pkg::*;

	frame_state_e state;
	logic         is_delim;
	// set after a drop until the broken frame's closing "&&" has gone by
	logic         skip;

	assign is_delim    = (rx_data == FRAME_DELIM);
	assign fifo_data   = rx_data;
	assign fifo_commit = (state == FR_CLOSE2);
	assign frame_good  = (state == FR_CLOSE2);

	always_comb begin
		fifo_push   = 1'b0;
		fifo_drop   = 1'b0;
		frame_error = 1'b0;
		if (rx_valid) begin
			unique case (state)
				FR_IDLE, FR_OPEN1: frame_error = !is_delim && !skip;
				FR_PAYLOAD: begin
					if (!is_delim) begin
						fifo_push   = !fifo_full;
						fifo_drop   = fifo_full;
						frame_error = fifo_full;
					end
				end
				FR_CLOSE1: begin
					fifo_drop   = !is_delim;
					frame_error = !is_delim;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= FR_IDLE;
			skip  <= 1'b0;
		end else begin
			unique case (state)
				FR_IDLE: begin
					if (rx_valid && is_delim)
						state <= FR_OPEN1;
				end
				FR_OPEN1: begin
					if (rx_valid) begin
						if (is_delim && skip) begin
							skip  <= 1'b0;
							state <= FR_IDLE;
						end else begin
							state <= is_delim ? FR_PAYLOAD : FR_IDLE;
						end
					end
				end
				FR_PAYLOAD: begin
					if (rx_valid && is_delim) begin
						state <= FR_CLOSE1;
					end else if (fifo_drop) begin
						skip  <= 1'b1;
						state <= FR_IDLE;
					end
				end
				FR_CLOSE1: begin
					if (rx_valid) begin
						skip  <= !is_delim;
						state <= is_delim ? FR_CLOSE2 : FR_IDLE;
					end
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== frame_tx.sv ====
/*
 * transmit framer
 * sends "&&", the requested number of fifo bytes, then "&&"
 */
`timescale 1ns/1ns
`default_nettype none

module frame_tx (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire                   start,
	input  wire uart_frame_pkg::len_t  length,
	output logic                  busy,
	input  wire uart_frame_pkg::byte_t fifo_head,
	input  wire                   fifo_empty,
	output logic                  fifo_pop,
	output uart_frame_pkg::byte_t  byte_out,
	output logic                  byte_req,
	input  wire                   byte_done
);
	import uart_frame_pkg::*;

	frame_state_e state;
	len_t         len_q;
	len_t         sent_cnt;
	logic         in_flight;

	assign busy = (state != FR_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= FR_IDLE;
			len_q     <= '0;
			sent_cnt  <= '0;
			in_flight <= 1'b0;
			fifo_pop  <= 1'b0;
			byte_out  <= '0;
			byte_req  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			fifo_pop <= 1'b0;
			unique case (state)
				FR_IDLE: begin
					if (start) begin
						len_q    <= length;
						sent_cnt <= '0;
						byte_out <= FRAME_DELIM;
						byte_req <= 1'b1;
						state    <= FR_OPEN1;
					end
				end
				FR_OPEN1: begin
					if (byte_done) begin
						byte_out <= FRAME_DELIM;
						byte_req <= 1'b1;
						state    <= FR_OPEN2;
					end
				end
				FR_OPEN2: begin
					if (byte_done) begin
						in_flight <= 1'b0;
						state     <= FR_PAYLOAD;
					end
				end
				FR_PAYLOAD: begin
					// head is not looked at again until the pop has landed
					if (in_flight) begin
						if (byte_done)
							in_flight <= 1'b0;
					end else if (sent_cnt == len_q) begin
						byte_out <= FRAME_DELIM;
						byte_req <= 1'b1;
						state    <= FR_CLOSE1;
					end else if (!fifo_empty) begin
						byte_out  <= fifo_head;
						byte_req  <= 1'b1;
						fifo_pop  <= 1'b1;
						sent_cnt  <= sent_cnt + 1'b1;
						in_flight <= 1'b1;
					end
				end
				FR_CLOSE1: begin
					if (byte_done) begin
						byte_out <= FRAME_DELIM;
						byte_req <= 1'b1;
						state    <= FR_CLOSE2;
					end
				end
				FR_CLOSE2: begin
					if (byte_done)
						state <= FR_IDLE;
				end
				default: state <= FR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== byte_fifo.sv ====
/*
 * synchronous show-ahead byte fifo
 * tentative and committed write pointers for commit or rollback of a frame
 */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo #(
	parameter int FIFO_AW = 4
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire                   push,
	input  wire uart_frame_pkg::byte_t push_data,
	input  wire                   pop,
	output uart_frame_pkg::byte_t  head,
	input  wire                   commit,
	input  wire                   drop,
	output logic                  full,
	output logic                  empty,
	output uart_frame_pkg::len_t   level
);
	import uart_frame_pkg::*;

	localparam int DEPTH = 2 ** FIFO_AW;
	localparam logic [FIFO_AW:0] DEPTH_P = (FIFO_AW + 1)'(DEPTH);

	byte_t            mem [DEPTH];
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] cm_ptr;
	logic [FIFO_AW:0] rd_ptr;
	logic [FIFO_AW:0] wr_next;
	logic [FIFO_AW:0] fill;
	logic [FIFO_AW:0] used;
	logic             do_push;
	logic             do_pop;

	// full counts tentative entries, empty and level only committed ones
	assign fill    = wr_ptr - rd_ptr;
	assign used    = cm_ptr - rd_ptr;
	assign full    = (fill == DEPTH_P);
	assign empty   = (cm_ptr == rd_ptr);
	assign level   = len_t'(used);
	assign head    = mem[rd_ptr[FIFO_AW-1:0]];
	assign do_push = push && !full && !drop;
	assign do_pop  = pop && !empty;
	assign wr_next = wr_ptr + 1'b1;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			cm_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (drop) begin
				wr_ptr <= cm_ptr;
			end else if (do_push) begin
				wr_ptr <= wr_next;
				if (commit)
					cm_ptr <= wr_next;
			end else if (commit) begin
				cm_ptr <= wr_ptr;
			end
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (do_push)
			mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
	end

	a_no_overflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		push |-> !full)
		else $error("byte_fifo push while full");

	a_no_underflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		pop |-> !empty)
		else $error("byte_fifo pop while empty");

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/*
 * 8N1 uart receiver
 * two-flop line synchronizer, mid-bit sampling, start bit recheck
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  wire                  sys_clk,
	input  wire                  sys_rst_n,
	input  wire                  rxd,
	output uart_frame_pkg::byte_t rx_data,
	output logic                 rx_valid
);
	import uart_frame_pkg::*;

	localparam int DIV_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_BIT - 1);
	localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(CLKS_PER_BIT / 2 - 1);

	bit_state_e       state;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	byte_t            shift;
	logic             rxd_meta;
	logic             rxd_s;
	logic             bit_end;
	logic             half_end;

	assign bit_end  = (div_cnt == DIV_LAST);
	assign half_end = (div_cnt == DIV_HALF);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= BIT_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			shift    <= '0;
			rx_data  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			unique case (state)
				BIT_IDLE: begin
					div_cnt <= '0;
					if (!rxd_s)
						state <= BIT_START;
				end
				BIT_START: begin
					div_cnt <= half_end ? '0 : div_cnt + 1'b1;
					// a glitch that is high again at mid-bit is no start bit
					if (half_end) begin
						bit_cnt <= '0;
						state   <= rxd_s ? BIT_IDLE : BIT_DATA;
					end
				end
				BIT_DATA: begin
					div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
					if (bit_end) begin
						shift   <= {rxd_s, shift[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= BIT_STOP;
					end
				end
				BIT_STOP: begin
					div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
					if (bit_end) begin
						rx_data  <= shift;
						rx_valid <= rxd_s;
						state    <= BIT_IDLE;
					end
				end
				default: state <= BIT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/*
 * 8N1 uart transmitter, lsb first
 * integer clock divider per bit, done pulse after the stop bit
 */
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire uart_frame_pkg::byte_t tx_data,
	input  wire                   tx_req,
	output logic                  txd,
	output logic                  tx_done
);
	import uart_frame_pkg::*;

	localparam int DIV_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_BIT - 1);

	bit_state_e       state;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	byte_t            shift;
	logic             bit_end;

	assign bit_end = (div_cnt == DIV_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= BIT_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			shift   <= '0;
			txd     <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (state == BIT_IDLE) begin
				div_cnt <= '0;
				if (tx_req) begin
					shift <= tx_data;
					txd   <= 1'b0;
					state <= BIT_START;
				end
			end else begin
				div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
			end
			if (bit_end) begin
				unique case (state)
					BIT_START: begin
						txd     <= shift[0];
						shift   <= shift >> 1;
						bit_cnt <= '0;
						state   <= BIT_DATA;
					end
					BIT_DATA: begin
						if (bit_cnt == 3'd7) begin
							txd   <= 1'b1;
							state <= BIT_STOP;
						end else begin
							txd     <= shift[0];
							shift   <= shift >> 1;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					BIT_STOP: begin
						tx_done <= 1'b1;
						state   <= BIT_IDLE;
					end
					default: state <= BIT_IDLE;
				endcase
			end
		end
	end

	// the framer waits for done before it asks for the next byte
	a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> state == BIT_IDLE)
		else $error("uart_tx request while a byte is in flight");

endmodule

`default_nettype wire

// ==== uart_frame_pkg.sv ====
/*
 * shared types for the uart frame controller
 * byte and count types, frame delimiter, register map, fsm encodings
 */
`default_nettype none

package uart_frame_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] len_t;
	typedef logic [1:0] wb_adr_t;

	// "&" marks both ends of a frame
	localparam byte_t FRAME_DELIM = 8'h26;

	localparam wb_adr_t REG_DATA   = 2'd0;
	localparam wb_adr_t REG_CTRL   = 2'd1;
	localparam wb_adr_t REG_LEVEL  = 2'd2;
	localparam wb_adr_t REG_FRAMES = 2'd3;

	// uart bit engines
	typedef enum logic [1:0] {BIT_IDLE, BIT_START, BIT_DATA, BIT_STOP} bit_state_e;

	// framer and deframer
	typedef enum logic [2:0] {
		FR_IDLE,
		FR_OPEN1,
		FR_OPEN2,
		FR_PAYLOAD,
		FR_CLOSE1,
		FR_CLOSE2
	} frame_state_e;

endpackage

`default_nettype wire
